// File: source/video_pkg.sv
package video_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and storage payloads
	//////////////////////////////////////////////////////////////////////

	// One CPU write as seen on the register port
	typedef struct packed {
		logic [9:0]  addr;
		logic [15:0] data;
	} bus_write_t;

	// Single map RAM write
	typedef struct packed {
		logic [5:0] entry;
		logic [7:0] color;
	} map_write_t;

	// Per layer scroll and priority
	typedef struct packed {
		logic [8:0] scroll_x;
		logic [8:0] scroll_y;
		logic [2:0] prio;
	} layer_regs_t;

	// Raster position
	typedef struct packed {
		logic [8:0] x;
		logic [8:0] y;
	} pixel_pos_t;

	// Sync and blank strobes, all active low
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank_n;
		logic vblank_n;
	} video_ctrl_t;

	// 4 bit per gun, blue on top like the board DAC
	typedef struct packed {
		logic [3:0] blue;
		logic [3:0] green;
		logic [3:0] red;
	} rgb_t;

	// Zero is transparent inside a layer
	typedef logic [7:0] color_index_t;

	//////////////////////////////////////////////////////////////////////
	// Constants
	//////////////////////////////////////////////////////////////////////

	// Master clocks per pixel
	localparam int PIXEL_DIV = 8;

	// Layer slots in register and map arrays
	localparam int LAYER_BG   = 0;
	localparam int LAYER_FG   = 1;
	localparam int LAYER_TEXT = 2;

	// Syncs released and both blanks asserted
	localparam video_ctrl_t CTRL_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1,
		hblank_n: 1'b0, vblank_n: 1'b0};

	// Register map, word addresses
	localparam logic [9:0] REG_SCROLL_BASE = 10'h000;
	localparam logic [9:0] REG_PRIO_BASE   = 10'h006;
	localparam logic [9:0] REG_MASK        = 10'h009;
	localparam logic [9:0] REG_BACKCOLOR   = 10'h00A;
	localparam logic [9:0] PALETTE_BASE    = 10'h100;
	localparam logic [9:0] MAP_BG_BASE     = 10'h200;
	localparam logic [9:0] MAP_FG_BASE     = 10'h240;
	localparam logic [9:0] MAP_TEXT_BASE   = 10'h280;

endpackage

// File: source/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
	parameter int H_ACTIVE = 288,
	parameter int H_TOTAL  = 384,
	parameter int V_ACTIVE = 224,
	parameter int V_TOTAL  = 264
) (
	input  logic                    clk_48m,
	input  logic                    rst_n,
	output logic                    pixel_en,
	output video_pkg::pixel_pos_t   pos,
	output video_pkg::video_ctrl_t  ctrl,
	output logic                    active
);
	import video_pkg::*;

	// Counter limits at counter width
	localparam logic [2:0] DIV_LAST = 3'(PIXEL_DIV - 1);
	localparam logic [8:0] H_LAST   = 9'(H_TOTAL - 1);
	localparam logic [8:0] V_LAST   = 9'(V_TOTAL - 1);
	localparam logic [8:0] H_ACT    = 9'(H_ACTIVE);
	localparam logic [8:0] V_ACT    = 9'(V_ACTIVE);
	// 8 pixel hsync, 4 pixels into hblank
	localparam logic [8:0] HS_START = 9'(H_ACTIVE + 4);
	localparam logic [8:0] HS_END   = 9'(H_ACTIVE + 12);
	// 2 line vsync, 2 lines into vblank
	localparam logic [8:0] VS_START = 9'(V_ACTIVE + 2);
	localparam logic [8:0] VS_END   = 9'(V_ACTIVE + 4);

	logic [2:0] div;
	pixel_pos_t next_pos;

	//////////////////////////////////////////////////////////////////////
	// Next raster position
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		next_pos = pos;
		if (pos.x == H_LAST) begin
			next_pos.x = '0;
			// Line done, step or wrap the frame
			next_pos.y = (pos.y == V_LAST) ? '0 : pos.y + 9'd1;
		end else begin
			next_pos.x = pos.x + 9'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Divider, counters and strobes
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			div      <= '0;
			pixel_en <= 1'b0;
			pos      <= '0;
			ctrl     <= CTRL_IDLE;
		end else begin
			div      <= (div == DIV_LAST) ? '0 : div + 3'd1;
			// One clock wide enable per pixel
			pixel_en <= (div == DIV_LAST);
			if (pixel_en) begin
				pos <= next_pos;
				// Strobes follow the new position so ctrl matches pos
				ctrl.hblank_n <= (next_pos.x < H_ACT);
				ctrl.vblank_n <= (next_pos.y < V_ACT);
				ctrl.hsync_n  <= !((next_pos.x >= HS_START) && (next_pos.x < HS_END));
				ctrl.vsync_n  <= !((next_pos.y >= VS_START) && (next_pos.y < VS_END));
			end
		end
	end

	// Visible area at the counter position
	assign active = ctrl.hblank_n && ctrl.vblank_n;

endmodule

// File: source/register_port.sv
`timescale 1ns/1ps

module register_port #(
	parameter int H_ACTIVE = 288,
	parameter int H_TOTAL  = 384,
	parameter int V_ACTIVE = 224,
	parameter int V_TOTAL  = 264
) (
	input  logic                                clk_48m,
	input  logic                                rst_n,
	input  logic                                wr_valid,
	input  video_pkg::bus_write_t               wr,
	output logic                                wr_ready,
	input  logic                                active,
	output video_pkg::layer_regs_t [2:0]        layer_regs,
	output logic [2:0]                          layer_mask,
	output video_pkg::color_index_t             back_color,
	output video_pkg::map_write_t [2:0]         map_wr,
	output logic [2:0]                          map_we,
	output video_pkg::color_index_t             pal_index,
	output video_pkg::rgb_t                     pal_data,
	output logic                                pal_we
);
	import video_pkg::*;

	// Palette writes wait for blanking so the frame needs some
	if ((H_TOTAL <= H_ACTIVE) && (V_TOTAL <= V_ACTIVE)) begin : g_no_blank
		$error("register_port needs horizontal or vertical blanking");
	end

	logic ready_q;
	logic is_pal;
	logic accept;

	//////////////////////////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////////////////////////

	// Palette page is 0x100 to 0x1FF
	assign is_pal   = (wr.addr[9:8] == PALETTE_BASE[9:8]);
	// Held low through reset, palette only in blank
	assign wr_ready = ready_q && !(is_pal && active);
	assign accept   = wr_valid && wr_ready;

	//////////////////////////////////////////////////////////////////////
	// Control registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			ready_q    <= 1'b0;
			layer_regs <= '0;
			layer_mask <= '0;
			back_color <= '0;
		end else begin
			ready_q <= 1'b1;
			if (accept) begin
				// Anything not listed is dropped here
				case (wr.addr)
					REG_SCROLL_BASE + 10'd0: layer_regs[LAYER_BG].scroll_x   <= wr.data[8:0];
					REG_SCROLL_BASE + 10'd1: layer_regs[LAYER_BG].scroll_y   <= wr.data[8:0];
					REG_SCROLL_BASE + 10'd2: layer_regs[LAYER_FG].scroll_x   <= wr.data[8:0];
					REG_SCROLL_BASE + 10'd3: layer_regs[LAYER_FG].scroll_y   <= wr.data[8:0];
					REG_SCROLL_BASE + 10'd4: layer_regs[LAYER_TEXT].scroll_x <= wr.data[8:0];
					REG_SCROLL_BASE + 10'd5: layer_regs[LAYER_TEXT].scroll_y <= wr.data[8:0];
					REG_PRIO_BASE + 10'd0:   layer_regs[LAYER_BG].prio       <= wr.data[2:0];
					REG_PRIO_BASE + 10'd1:   layer_regs[LAYER_FG].prio       <= wr.data[2:0];
					REG_PRIO_BASE + 10'd2:   layer_regs[LAYER_TEXT].prio     <= wr.data[2:0];
					REG_MASK:                layer_mask                      <= wr.data[2:0];
					REG_BACKCOLOR:           back_color                      <= wr.data[7:0];
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Map and palette steering
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		// Same payload to every map, enable picks the layer
		for (int i = 0; i < 3; i++) begin
			map_wr[i].entry = wr.addr[5:0];
			map_wr[i].color = wr.data[7:0];
		end
		// 64 entry blocks
		map_we[LAYER_BG]   = accept && (wr.addr[9:6] == MAP_BG_BASE[9:6]);
		map_we[LAYER_FG]   = accept && (wr.addr[9:6] == MAP_FG_BASE[9:6]);
		map_we[LAYER_TEXT] = accept && (wr.addr[9:6] == MAP_TEXT_BASE[9:6]);
	end

	assign pal_index = wr.addr[7:0];
	assign pal_data  = rgb_t'(wr.data[11:0]);
	assign pal_we    = accept && is_pal;

endmodule

// File: source/tile_layer.sv
`timescale 1ns/1ps

module tile_layer (
	input  logic                      clk_48m,
	input  logic                      pixel_en,
	input  video_pkg::pixel_pos_t     pos,
	input  video_pkg::layer_regs_t    regs,
	input  video_pkg::map_write_t     map_wr,
	input  logic                      map_we,
	output video_pkg::color_index_t   index
);
	import video_pkg::*;

	// 8x8 tiles, one solid colour each
	color_index_t map_ram [64];

	logic [8:0] sx;
	logic [8:0] sy;
	logic [5:0] entry;

	//////////////////////////////////////////////////////////////////////
	// CPU side map write
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_48m) begin
		if (map_we) begin
			map_ram[map_wr.entry] <= map_wr.color;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Scrolled lookup
	//////////////////////////////////////////////////////////////////////

	// Scroll wraps at 512, the map repeats every 64 pixels
	assign sx = pos.x + regs.scroll_x;
	assign sy = pos.y + regs.scroll_y;

	// Row times 8 plus column
	assign entry = {sy[5:3], sx[5:3]};

	// Index lands one pixel behind the position
	always_ff @(posedge clk_48m) begin
		if (pixel_en) begin
			index <= map_ram[entry];
		end
	end

endmodule

// File: source/layer_mixer.sv
`timescale 1ns/1ps

module layer_mixer (
	input  logic                             clk_48m,
	input  logic                             rst_n,
	input  logic                             pixel_en,
	input  video_pkg::color_index_t          bg,
	input  video_pkg::color_index_t          fg,
	input  video_pkg::color_index_t          text,
	input  video_pkg::layer_regs_t [2:0]     layer_regs,
	input  logic [2:0]                       layer_mask,
	input  video_pkg::color_index_t          back_color,
	output video_pkg::color_index_t          dot
);
	import video_pkg::*;

	color_index_t [2:0] idx;
	logic [2:0]         compete;
	logic               found;
	logic [2:0]         best_prio;
	color_index_t       winner;

	// Same slot order as the registers
	assign idx[LAYER_BG]   = bg;
	assign idx[LAYER_FG]   = fg;
	assign idx[LAYER_TEXT] = text;

	//////////////////////////////////////////////////////////////////////
	// Priority select
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		// Masked or transparent layers drop out
		for (int i = 0; i < 3; i++) begin
			compete[i] = !layer_mask[i] && (idx[i] != '0);
		end
		found     = 1'b0;
		best_prio = '0;
		// Nothing opaque shows the back colour
		winner    = back_color;
		// Scan bg to text, >= hands ties to the later layer
		for (int i = 0; i < 3; i++) begin
			if (compete[i] && (!found || (layer_regs[i].prio >= best_prio))) begin
				found     = 1'b1;
				best_prio = layer_regs[i].prio;
				winner    = idx[i];
			end
		end
	end

	// Second pixel stage
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			dot <= '0;
		end else if (pixel_en) begin
			dot <= winner;
		end
	end

endmodule

// File: source/palette_lookup.sv
`timescale 1ns/1ps

module palette_lookup (
	input  logic                       clk_48m,
	input  logic                       rst_n,
	input  logic                       pixel_en,
	input  video_pkg::color_index_t    dot,
	input  video_pkg::video_ctrl_t     ctrl_in,
	input  video_pkg::color_index_t    pal_index,
	input  video_pkg::rgb_t            pal_data,
	input  logic                       pal_we,
	output video_pkg::rgb_t            vid_rgb,
	output video_pkg::video_ctrl_t     vid_ctrl
);
	import video_pkg::*;

	// 256 x 12 colour RAM
	rgb_t pal_ram [256];

	video_ctrl_t ctrl_d1;
	video_ctrl_t ctrl_d2;
	logic        blank;

	//////////////////////////////////////////////////////////////////////
	// Palette write
	//////////////////////////////////////////////////////////////////////

	// Only ever written in blank
	always_ff @(posedge clk_48m) begin
		if (pal_we) begin
			pal_ram[pal_index] <= pal_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Lookup and ctrl delay
	//////////////////////////////////////////////////////////////////////

	// ctrl_d2 belongs to the dot now at the input
	assign blank = !ctrl_d2.hblank_n || !ctrl_d2.vblank_n;

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			ctrl_d1  <= CTRL_IDLE;
			ctrl_d2  <= CTRL_IDLE;
			vid_ctrl <= CTRL_IDLE;
			vid_rgb  <= '0;
		end else if (pixel_en) begin
			// Three pixel delay to match layer, mixer and palette
			ctrl_d1  <= ctrl_in;
			ctrl_d2  <= ctrl_d1;
			vid_ctrl <= ctrl_d2;
			// Black outside the visible area
			vid_rgb  <= blank ? '0 : pal_ram[dot];
		end
	end

endmodule

// File: source/video_top.sv
`timescale 1ns/1ps

module video_top #(
	parameter int H_ACTIVE = 288,
	parameter int H_TOTAL  = 384,
	parameter int V_ACTIVE = 224,
	parameter int V_TOTAL  = 264
) (
	input  logic                      clk_48m,
	input  logic                      rst_n,
	input  logic                      wr_valid,
	input  video_pkg::bus_write_t     wr,
	output logic                      wr_ready,
	output logic                      vid_pixel_en,
	output video_pkg::rgb_t           vid_rgb,
	output video_pkg::video_ctrl_t    vid_ctrl
);
	import video_pkg::*;

	pixel_pos_t          pos;
	video_ctrl_t         ctrl;
	logic                active;
	layer_regs_t [2:0]   layer_regs;
	logic [2:0]          layer_mask;
	color_index_t        back_color;
	map_write_t [2:0]    map_wr;
	logic [2:0]          map_we;
	color_index_t        pal_index;
	rgb_t                pal_data;
	logic                pal_we;
	color_index_t        bg_index;
	color_index_t        fg_index;
	color_index_t        text_index;
	color_index_t        dot;

	//////////////////////////////////////////////////////////////////////
	// Timing and CPU port
	//////////////////////////////////////////////////////////////////////

	// Pixel enable goes straight out as the video clock enable
	video_timing #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
	) timing_i (
		.clk_48m(clk_48m), .rst_n(rst_n), .pixel_en(vid_pixel_en),
		.pos(pos), .ctrl(ctrl), .active(active)
	);

	register_port #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
	) regs_i (
		.clk_48m(clk_48m), .rst_n(rst_n), .wr_valid(wr_valid), .wr(wr),
		.wr_ready(wr_ready), .active(active), .layer_regs(layer_regs),
		.layer_mask(layer_mask), .back_color(back_color), .map_wr(map_wr),
		.map_we(map_we), .pal_index(pal_index), .pal_data(pal_data), .pal_we(pal_we)
	);

	//////////////////////////////////////////////////////////////////////
	// Tile layers
	//////////////////////////////////////////////////////////////////////
	tile_layer bg_layer (
		.clk_48m(clk_48m), .pixel_en(vid_pixel_en), .pos(pos),
		.regs(layer_regs[LAYER_BG]), .map_wr(map_wr[LAYER_BG]),
		.map_we(map_we[LAYER_BG]), .index(bg_index)
	);

	tile_layer fg_layer (
		.clk_48m(clk_48m), .pixel_en(vid_pixel_en), .pos(pos),
		.regs(layer_regs[LAYER_FG]), .map_wr(map_wr[LAYER_FG]),
		.map_we(map_we[LAYER_FG]), .index(fg_index)
	);

	tile_layer text_layer (
		.clk_48m(clk_48m), .pixel_en(vid_pixel_en), .pos(pos),
		.regs(layer_regs[LAYER_TEXT]), .map_wr(map_wr[LAYER_TEXT]),
		.map_we(map_we[LAYER_TEXT]), .index(text_index)
	);

	//////////////////////////////////////////////////////////////////////
	// Mix and colour out
	//////////////////////////////////////////////////////////////////////
	layer_mixer mixer_i (
		.clk_48m(clk_48m), .rst_n(rst_n), .pixel_en(vid_pixel_en),
		.bg(bg_index), .fg(fg_index), .text(text_index), .layer_regs(layer_regs),
		.layer_mask(layer_mask), .back_color(back_color), .dot(dot)
	);

	palette_lookup palette_i (
		.clk_48m(clk_48m), .rst_n(rst_n), .pixel_en(vid_pixel_en), .dot(dot),
		.ctrl_in(ctrl), .pal_index(pal_index), .pal_data(pal_data), .pal_we(pal_we),
		.vid_rgb(vid_rgb), .vid_ctrl(vid_ctrl)
	);

endmodule

// File: dv/video_asserts.sv
`timescale 1ns/1ps

module video_asserts #(
	parameter int H_ACTIVE = 288,
	parameter int V_ACTIVE = 224
) (
	input logic                    clk_48m,
	input logic                    rst_n,
	input logic                    wr_valid,
	input video_pkg::bus_write_t   wr,
	input logic                    wr_ready,
	input video_pkg::pixel_pos_t   pos,
	input video_pkg::rgb_t         vid_rgb,
	input video_pkg::video_ctrl_t  vid_ctrl
);
	import video_pkg::*;

	// Master holds the request while it waits
	wr_hold: assert property (@(posedge clk_48m) disable iff (rst_n)
		(wr_valid && !wr_ready) |=> (wr_valid && $stable(wr)))
		else $error("wr changed or dropped while waiting for wr_ready");

	// Palette ready only while the counters sit in blanking
	pal_ready: assert property (@(posedge clk_48m) disable iff (rst_n)
		(wr_ready && (wr.addr[9:8] == PALETTE_BASE[9:8])) |->
		((pos.x >= 9'(H_ACTIVE)) || (pos.y >= 9'(V_ACTIVE))))
		else $error("wr_ready high for a palette address in active display");

	// Black outside the visible area
	blank_black: assert property (@(posedge clk_48m)
		(!vid_ctrl.hblank_n || !vid_ctrl.vblank_n) |-> (vid_rgb == '0))
		else $error("rgb not zero while blanked");

endmodule

bind video_top video_asserts #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) asserts_i (
	.clk_48m(clk_48m), .rst_n(rst_n), .wr_valid(wr_valid), .wr(wr),
	.wr_ready(wr_ready), .pos(pos), .vid_rgb(vid_rgb), .vid_ctrl(vid_ctrl)
);

// File: dv/video_tb.sv
`timescale 1ns/1ps

module video_tb;
	import video_pkg::*;

	localparam int H_ACTIVE = 64;
	localparam int H_TOTAL  = 80;
	localparam int V_ACTIVE = 32;
	localparam int V_TOTAL  = 40;

	logic        clk_48m;
	logic        rst_n;
	logic        wr_valid;
	bus_write_t  wr;
	logic        wr_ready;
	logic        vid_pixel_en;
	rgb_t        vid_rgb;
	video_ctrl_t vid_ctrl;
	video_ctrl_t prev_ctrl;

	int errors;
	int checks;
	int tests;
	logic [31:0] lcg_state;

	// Reference state of the display registers and RAMs
	logic [7:0]  map_m [3][64];
	logic [11:0] pal_m [256];
	int          scx [3];
	int          scy [3];
	int          prio_m [3];
	logic [2:0]  mask_m;
	logic [7:0]  back_m;

	video_top #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
	) dut_i (
		.clk_48m(clk_48m), .rst_n(rst_n), .wr_valid(wr_valid), .wr(wr),
		.wr_ready(wr_ready), .vid_pixel_en(vid_pixel_en), .vid_rgb(vid_rgb),
		.vid_ctrl(vid_ctrl)
	);

	initial begin
		clk_48m = 1'b0;
		forever #20 clk_48m = ~clk_48m;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {17'd0, lcg_state[30:16]};
	endfunction

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s: got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic end_test(input string name, input int errs0);
		tests++;
		$display("test %s done with %0d mismatches", name, errors - errs0);
	endtask

	// One CPU write, held until wr_ready; returns clocks waited
	task automatic bus_write(input logic [9:0] addr, input logic [15:0] data,
		output int waited);
		logic done;
		done   = 1'b0;
		waited = 0;
		@(posedge clk_48m);
		wr       <= '{addr: addr, data: data};
		wr_valid <= 1'b1;
		while (!done) begin
			@(posedge clk_48m);
			done = wr_ready;
			waited++;
			if (!done && waited > 4 * H_TOTAL * PIXEL_DIV) begin
				abort_on_timeout("wr_ready");
			end
		end
		wr_valid <= 1'b0;
	endtask

	task automatic write_map(input int layer, input int entry, input logic [7:0] color);
		int w;
		bus_write(MAP_BG_BASE + 10'(layer * 64 + entry), {8'd0, color}, w);
		map_m[layer][entry] = color;
	endtask

	task automatic write_pal(input int idx, input logic [11:0] color, output int w);
		bus_write(PALETTE_BASE + 10'(idx), {4'd0, color}, w);
		pal_m[idx] = color;
	endtask

	task automatic write_reg(input logic [9:0] addr, input int value);
		int w;
		bus_write(addr, 16'(value), w);
		case (addr)
			10'h000: scx[0] = value;
			10'h001: scy[0] = value;
			10'h002: scx[1] = value;
			10'h003: scy[1] = value;
			10'h004: scx[2] = value;
			10'h005: scy[2] = value;
			10'h006: prio_m[0] = value;
			10'h007: prio_m[1] = value;
			10'h008: prio_m[2] = value;
			10'h009: mask_m = 3'(value);
			10'h00A: back_m = 8'(value);
			default: ;
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Screen tracking
	//////////////////////////////////////////////////////////////////////

	// Waits for the next output pixel, samples on the falling edge
	task automatic next_pixel();
		int   n;
		logic got;
		n         = 0;
		got       = 1'b0;
		prev_ctrl = vid_ctrl;
		while (!got) begin
			@(posedge clk_48m);
			got = vid_pixel_en;
			n++;
			if (!got && n > 2 * PIXEL_DIV) begin
				abort_on_timeout("pixel enable");
			end
		end
		@(negedge clk_48m);
	endtask

	function automatic logic hs_fall();
		return prev_ctrl.hsync_n && !vid_ctrl.hsync_n;
	endfunction

	function automatic logic vs_fall();
		return prev_ctrl.vsync_n && !vid_ctrl.vsync_n;
	endfunction

	// Stops on output pixel (0,0), where both blanks release
	task automatic wait_frame_start();
		int n;
		n = 0;
		// Last register write reaches the layer lookup first
		repeat (2) begin
			next_pixel();
		end
		do begin
			next_pixel();
			n++;
			if (n > 2 * H_TOTAL * V_TOTAL) begin
				abort_on_timeout("frame start");
			end
		end while (!(!prev_ctrl.hblank_n && vid_ctrl.hblank_n &&
			!prev_ctrl.vblank_n && vid_ctrl.vblank_n));
	endtask

	// Colour the screen should show at output position x, y
	function automatic logic [11:0] expected_rgb(input int x, input int y);
		int         e;
		int         best;
		logic       found;
		logic [7:0] c;
		logic [7:0] win;
		if (x >= H_ACTIVE || y >= V_ACTIVE) begin
			return 12'd0;
		end
		found = 1'b0;
		best  = 0;
		win   = back_m;
		// Text first, a later layer only wins with a strictly higher priority
		for (int l = 2; l >= 0; l--) begin
			e = (((y + scy[l]) >> 3) & 7) * 8 + (((x + scx[l]) >> 3) & 7);
			c = map_m[l][e];
			if (!mask_m[l] && c != 8'd0 && (!found || prio_m[l] > best)) begin
				found = 1'b1;
				best  = prio_m[l];
				win   = c;
			end
		end
		return pal_m[win];
	endfunction

	task automatic check_frame(input string tag);
		wait_frame_start();
		for (int y = 0; y < V_TOTAL; y++) begin
			for (int x = 0; x < H_TOTAL; x++) begin
				if (x != 0 || y != 0) begin
					next_pixel();
				end
				compare(32'(vid_rgb), 32'(expected_rgb(x, y)),
					$sformatf("%s rgb at %0d,%0d", tag, x, y));
				compare(32'(vid_ctrl.hblank_n), 32'(x < H_ACTIVE),
					$sformatf("%s hblank_n at %0d,%0d", tag, x, y));
				compare(32'(vid_ctrl.vblank_n), 32'(y < V_ACTIVE),
					$sformatf("%s vblank_n at %0d,%0d", tag, x, y));
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_timing();
		int errs0;
		int n;
		errs0 = errors;
		@(negedge clk_48m);
		compare(32'(vid_ctrl.hsync_n), 32'd1, "hsync_n after reset");
		compare(32'(vid_ctrl.vsync_n), 32'd1, "vsync_n after reset");
		compare(32'(vid_rgb), 32'd0, "rgb after reset");
		// First hsync fall, then the line length
		n = 0;
		do begin
			next_pixel();
			n++;
		end while (!hs_fall() && n < 2 * H_TOTAL * V_TOTAL);
		n = 0;
		do begin
			next_pixel();
			n++;
		end while (!hs_fall() && n < 2 * H_TOTAL);
		compare(32'(n), 32'(H_TOTAL), "pixels between hsync falls");
		n = 0;
		do begin
			next_pixel();
			n++;
		end while (!vid_ctrl.hsync_n && n < H_TOTAL);
		compare(32'(n), 32'd8, "hsync_n low width");
		// Lines between vsync falls
		n = 0;
		do begin
			next_pixel();
			n++;
		end while (!vs_fall() && n < 2 * H_TOTAL * V_TOTAL);
		n = 0;
		do begin
			next_pixel();
			if (hs_fall()) begin
				n++;
			end
		end while (!vs_fall() && n < 2 * V_TOTAL);
		compare(32'(n), 32'(V_TOTAL), "lines between vsync falls");
		end_test("timing", errs0);
	endtask

	task automatic test_back_color();
		int errs0;
		int w;
		errs0 = errors;
		for (int l = 0; l < 3; l++) begin
			for (int e = 0; e < 64; e++) begin
				write_map(l, e, 8'd0);
			end
		end
		for (int i = 0; i < 16; i++) begin
			write_pal(i, 12'(lcg_next()), w);
		end
		write_reg(REG_BACKCOLOR, 5);
		check_frame("back");
		end_test("back_color", errs0);
	endtask

	task automatic test_scroll();
		int errs0;
		errs0 = errors;
		for (int e = 0; e < 64; e++) begin
			write_map(0, e, 8'(lcg_next() % 16));
		end
		write_reg(REG_SCROLL_BASE, int'(lcg_next() % 512));
		write_reg(REG_SCROLL_BASE + 10'd1, int'(lcg_next() % 512));
		check_frame("scroll");
		end_test("scroll", errs0);
	endtask

	task automatic test_priority();
		int errs0;
		int sets [4][3];
		errs0 = errors;
		sets = '{'{0, 0, 0}, '{1, 2, 3}, '{3, 2, 1}, '{2, 2, 1}};
		for (int l = 1; l < 3; l++) begin
			for (int e = 0; e < 64; e++) begin
				write_map(l, e, 8'(lcg_next() % 16));
			end
			write_reg(REG_SCROLL_BASE + 10'(2 * l), int'(lcg_next() % 512));
			write_reg(REG_SCROLL_BASE + 10'(2 * l + 1), int'(lcg_next() % 512));
		end
		for (int s = 0; s < 4; s++) begin
			for (int l = 0; l < 3; l++) begin
				write_reg(REG_PRIO_BASE + 10'(l), sets[s][l]);
			end
			check_frame($sformatf("prio set %0d", s));
		end
		end_test("priority", errs0);
	endtask

	task automatic test_mask();
		int errs0;
		errs0 = errors;
		for (int b = 0; b < 3; b++) begin
			write_reg(REG_MASK, 1 << b);
			check_frame($sformatf("mask bit %0d", b));
		end
		write_reg(REG_MASK, 0);
		end_test("mask", errs0);
	endtask

	task automatic test_backpressure();
		int errs0;
		int w;
		errs0 = errors;
		// Whole screen shows the back colour
		write_reg(REG_MASK, 7);
		wait_frame_start();
		// Output at x 10 of line 5 means the counters are mid display
		repeat (H_TOTAL * 5 + 10) begin
			next_pixel();
		end
		write_pal(int'(back_m), ~pal_m[back_m], w);
		compare(32'(w >= 40 * PIXEL_DIV), 32'd1, "palette write accepted before blank");
		compare(32'(w <= H_TOTAL * PIXEL_DIV), 32'd1, "palette write not taken within a line");
		check_frame("new colour");
		end_test("backpressure", errs0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		rst_n     = 1'b1;
		wr_valid  = 1'b0;
		wr        = '0;
		prev_ctrl = CTRL_IDLE;
		errors    = 0;
		checks    = 0;
		tests     = 0;
		lcg_state = 32'h5551;
		mask_m    = '0;
		back_m    = '0;
		for (int l = 0; l < 3; l++) begin
			scx[l]    = 0;
			scy[l]    = 0;
			prio_m[l] = 0;
		end
		repeat (4) @(posedge clk_48m);
		rst_n <= 1'b0;
		test_timing();
		test_back_color();
		test_scroll();
		test_priority();
		test_mask();
		test_backpressure();
		$display("%0d tests, %0d checks, %0d mismatches", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: project.f
source/video_pkg.sv
source/video_timing.sv
source/register_port.sv
source/tile_layer.sv
source/layer_mixer.sv
source/palette_lookup.sv
source/video_top.sv
dv/video_asserts.sv
dv/video_tb.sv

// File: Makefile
TOP := video_tb

all: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build lint clean
